// ==== Makefile ====
SIM      = verilator
VFLAGS   = --binary --timing --assert -j 0
TOP      = pc_bus_tb
FILELIST = files.f
OBJ_DIR  = obj_dir
SIM_BIN  = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	-./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "No pass result in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
src/pc_bus_pkg.sv
src/local_bus_if.sv
src/bus_cycle_unit.sv
src/bus_controller.sv
src/bus_demux.sv
src/mem_io_target.sv
src/pc_bus_top.sv
sim/pc_bus_tb.sv

// ==== sim/pc_bus_tb.sv ====
`timescale 1ns/1ps

module pc_bus_tb;

   localparam int         mem_depth  = 256;
   localparam int         io_ports   = 4;
   localparam logic [7:0] int_vector = 8'h08;
   localparam int         mem_aw     = $clog2(mem_depth);
   localparam int         port_w     = $clog2(io_ports);

   localparam int n_mem        = 16;
   localparam int n_io         = 8;
   localparam int aen_stall_a  = 5;
   localparam int aen_stall_b  = 3;
   localparam int cen_idle     = 6;
   localparam int cen_hold     = 10;
   localparam int n_tx         = 2 * n_mem + 2 * io_ports + n_io + 7;
   localparam int stall_cycles = aen_stall_a + aen_stall_b + cen_idle + cen_hold;
   localparam int watchdog_cycles = n_tx * 20 + stall_cycles + 20;

   logic                          clk;
   logic                          rst;
   logic                          req;
   logic [pc_bus_pkg::st_w-1:0]   req_kind;
   logic [pc_bus_pkg::addr_w-1:0] req_addr;
   logic [pc_bus_pkg::data_w-1:0] req_wdata;
   logic                          aen_n;
   logic                          cen;
   logic                          ready;
   logic                          done;
   logic [pc_bus_pkg::data_w-1:0] rdata;

   integer seed;
   int     accepts = 0;
   int     dones   = 0;

   // Reference model of the target
   logic [7:0]                    model_mem [mem_depth];
   logic [7:0]                    model_port [io_ports];
   logic [pc_bus_pkg::addr_w-1:0] wr_addr [n_mem];

   pc_bus_top #(
      .mem_depth  (mem_depth),
      .io_ports   (io_ports),
      .int_vector (int_vector)
   ) dut_i (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .req_kind  (req_kind),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .aen_n     (aen_n),
      .cen       (cen),
      .ready     (ready),
      .done      (done),
      .rdata     (rdata)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      abort_run($sformatf("run hung, no end after %0d cycles", watchdog_cycles));
   end

   // Accepted requests and done pulses
   always @(posedge clk) begin
      if (!rst) begin
         if (req && ready) accepts <= accepts + 1;
         if (done) dones <= dones + 1;
      end
   end

   done_pulse_a: assert property (@(posedge clk) disable iff (rst) done |=> !done)
      else abort_run("done stayed high for more than one cycle");

   done_busy_a: assert property (@(posedge clk) disable iff (rst) done |-> !ready)
      else abort_run("done and ready were high together");

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      assert (act === exp)
         else abort_run($sformatf("mismatch at %0t ns: %s expected 8'h%02h, got 8'h%02h",
                                  $time, name, exp, act));
   endtask

   // One bus request from drive to done with optional stalls and a competing req
   task automatic run_cycle(
      input  logic [2:0]  kind,
      input  logic [19:0] addr,
      input  logic [7:0]  wdata,
      input  int          aen_hold,
      input  int          cen_low,
      input  bit          noise,
      output logic [7:0]  rd
   );
      int lat;
      lat = 0;
      @(posedge clk);
      req       <= 1'b1;
      req_kind  <= kind;
      req_addr  <= addr;
      req_wdata <= wdata;
      if (aen_hold > 0) aen_n <= 1'b1;
      if (cen_low > 0) cen <= 1'b0;
      @(posedge clk);
      while (!ready) @(posedge clk);
      if (noise) begin
         req_kind  <= pc_bus_pkg::st_mem_write; // Must be ignored while busy
         req_wdata <= ~wdata;
      end else begin
         req <= 1'b0;
      end
      while (!done) begin
         @(posedge clk);
         lat++;
         if (lat == aen_hold) aen_n <= 1'b0;
         if (lat == cen_low) cen <= 1'b1;
         if (lat > 40 + aen_hold + cen_low) abort_run("done never arrived for a request");
      end
      req <= 1'b0;
      rd = rdata;
      if (cen_low > 0) begin
         assert (lat >= cen_low + 4)
            else abort_run("done arrived while cen was still low");
      end else begin
         assert (lat == aen_hold + 4)
            else abort_run($sformatf("mismatch at %0t ns: done latency expected %0d, got %0d",
                                     $time, aen_hold + 4, lat));
      end
   endtask

   task automatic write_mem(input logic [19:0] addr, input logic [7:0] data,
                            input int aen_hold, input bit noise);
      logic [7:0] unused_rd;
      run_cycle(pc_bus_pkg::st_mem_write, addr, data, aen_hold, 0, noise, unused_rd);
      model_mem[addr[mem_aw-1:0]] = data;
   endtask

   task automatic write_port(input logic [19:0] addr, input logic [7:0] data);
      logic [7:0] unused_rd;
      run_cycle(pc_bus_pkg::st_io_write, addr, data, 0, 0, 1'b0, unused_rd);
      model_port[addr[port_w-1:0]] = data;
   endtask

   task automatic read_check(input logic [2:0] kind, input logic [19:0] addr,
                             input int aen_hold, input int cen_low);
      logic [7:0] exp;
      logic [7:0] got;
      if (kind == pc_bus_pkg::st_inta) exp = int_vector;
      else if (kind == pc_bus_pkg::st_io_read) exp = model_port[addr[port_w-1:0]];
      else exp = model_mem[addr[mem_aw-1:0]];
      run_cycle(kind, addr, 8'h00, aen_hold, cen_low, 1'b0, got);
      check_byte("rdata", exp, got);
   endtask

   initial begin
      logic [31:0] r;
      logic [19:0] a;
      seed      = 42;
      rst       = 1'b1;
      req       = 1'b0;
      req_kind  = pc_bus_pkg::st_passive;
      req_addr  = '0;
      req_wdata = '0;
      aen_n     = 1'b0;
      cen       = 1'b1;
      for (int p = 0; p < io_ports; p++) begin
         model_port[p] = 8'h00;
      end
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      assert (ready === 1'b1 && done === 1'b0)
         else abort_run("ready low or done high after reset");

      // Memory writes and then reads with code fetch and aliased addresses
      for (int i = 0; i < n_mem; i++) begin
         r = $random(seed);
         wr_addr[i] = r[19:0];
         r = $random(seed);
         write_mem(wr_addr[i], r[7:0], 0, 1'b0);
      end
      for (int i = 0; i < n_mem; i++) begin
         a = wr_addr[i];
         if (i % 2 == 1) a = a + 20'(mem_depth * i); // Same byte under other upper bits
         read_check(i % 3 == 0 ? pc_bus_pkg::st_code : pc_bus_pkg::st_mem_read, a, 0, 0);
      end

      // Unwritten ports read zero
      for (int p = 0; p < io_ports; p++) begin
         a = 20'(p);
         read_check(pc_bus_pkg::st_io_read, a, 0, 0);
      end
      for (int i = 0; i < n_io; i++) begin
         r = $random(seed);
         a = r[19:0];
         r = $random(seed);
         write_port(a, r[7:0]);
      end
      for (int p = 0; p < io_ports; p++) begin
         r = $random(seed);
         a = r[19:0];
         a[port_w-1:0] = p[port_w-1:0];
         read_check(pc_bus_pkg::st_io_read, a, 0, 0);
      end

      read_check(pc_bus_pkg::st_inta, r[19:0], 0, 0);

      // Competing req while busy leaves memory alone
      r = $random(seed);
      write_mem(wr_addr[0], r[7:0], 0, 1'b1);
      read_check(pc_bus_pkg::st_mem_read, wr_addr[0], 0, 0);

      // aen_n held high stretches T1
      read_check(pc_bus_pkg::st_mem_read, wr_addr[1], aen_stall_a, 0);
      r = $random(seed);
      write_mem(wr_addr[2], r[7:0], aen_stall_b, 1'b0);
      read_check(pc_bus_pkg::st_mem_read, wr_addr[2], 0, 0);

      @(posedge clk);
      cen <= 1'b0;
      repeat (cen_idle) begin
         @(posedge clk);
         assert (ready === 1'b1 && done === 1'b0)
            else abort_run("ready dropped or done rose while idle with cen low");
      end
      cen <= 1'b1;
      read_check(pc_bus_pkg::st_mem_read, wr_addr[3], 0, cen_hold);

      repeat (2) @(posedge clk);
      if (accepts == n_tx && dones == n_tx) begin
         $display("TEST PASS");
         $finish;
      end else begin
         abort_run($sformatf("mismatch at %0t ns: accepts/dones expected %0d, got %0d/%0d",
                             $time, n_tx, accepts, dones));
      end
   end

endmodule

// ==== src/bus_controller.sv ====
`timescale 1ns/1ps

module bus_controller (
   input  logic                        clk,
   input  logic                        rst,
   input  logic [pc_bus_pkg::st_w-1:0] s_n,
   input  logic                        aen_n,
   input  logic                        cen,   // Output enable
   local_bus_if.ctrl                   bus
);

   // Sequencer states, s0 is idle
   localparam logic [1:0] s0 = 2'b00;
   localparam logic [1:0] s1 = 2'b01;
   localparam logic [1:0] s2 = 2'b10;
   localparam logic [1:0] s3 = 2'b11;

   logic [1:0] state;
   logic [1:0] next_state;

   // Latched command flags
   logic mrdc_f;
   logic amwc_f;
   logic iorc_f;
   logic aiowc_f;
   logic inta_f;

   logic active;    // Status is neither halt nor passive
   logic start;     // Leaving s0 this cycle
   logic cmd_phase;
   logic rd_kind;
   logic wr_kind;

   // Ungated outputs
   logic ale_s;
   logic dtr_s;
   logic den_s;

   assign active = (s_n != pc_bus_pkg::st_halt) && (s_n != pc_bus_pkg::st_passive);
   assign start  = (state == s0) && !aen_n && active;

   always_comb begin
      case (state)
         s0:      next_state = start ? s1 : s0;
         s1:      next_state = s2;
         s2:      next_state = s3;
         default: next_state = s0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= s0;
      end else begin
         state <= next_state;
      end
   end

   // Decode on the ALE cycle so s1 already sees the new command
   always_ff @(posedge clk) begin
      if (rst) begin
         mrdc_f  <= 1'b0;
         amwc_f  <= 1'b0;
         iorc_f  <= 1'b0;
         aiowc_f <= 1'b0;
         inta_f  <= 1'b0;
      end else if (start) begin
         mrdc_f  <= (s_n == pc_bus_pkg::st_code) || (s_n == pc_bus_pkg::st_mem_read);
         amwc_f  <= (s_n == pc_bus_pkg::st_mem_write);
         iorc_f  <= (s_n == pc_bus_pkg::st_io_read);
         aiowc_f <= (s_n == pc_bus_pkg::st_io_write);
         inta_f  <= (s_n == pc_bus_pkg::st_inta);
      end
   end

   assign cmd_phase = (state == s1) || (state == s2);
   assign rd_kind   = mrdc_f || iorc_f || inta_f;
   assign wr_kind   = amwc_f || aiowc_f;

   assign ale_s = start;
   assign dtr_s = !((state != s0) && rd_kind);                   // Receive for reads
   assign den_s = ((state == s2) && rd_kind) || ((state != s0) && wr_kind);

   // cen forces every output to its idle level
   assign bus.mrdc_n  = cen ? !(cmd_phase && mrdc_f)  : 1'b1;
   assign bus.amwc_n  = cen ? !(cmd_phase && amwc_f)  : 1'b1;
   assign bus.iorc_n  = cen ? !(cmd_phase && iorc_f)  : 1'b1;
   assign bus.aiowc_n = cen ? !(cmd_phase && aiowc_f) : 1'b1;
   assign bus.inta_n  = cen ? !(cmd_phase && inta_f)  : 1'b1;
   assign bus.dtr     = cen ? dtr_s : 1'b1;
   assign bus.den     = cen ? den_s : 1'b0;
   assign bus.ale     = cen ? ale_s : 1'b0;

endmodule

// ==== src/bus_cycle_unit.sv ====
`timescale 1ns/1ps

module bus_cycle_unit (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             req,
   input  logic [pc_bus_pkg::st_w-1:0]      req_kind,
   input  logic [pc_bus_pkg::addr_w-1:0]    req_addr,
   input  logic [pc_bus_pkg::data_w-1:0]    req_wdata,
   input  logic [pc_bus_pkg::data_w-1:0]    ad_in,
   output logic                             ready,
   output logic                             done,
   output logic [pc_bus_pkg::data_w-1:0]    rdata,
   output logic [pc_bus_pkg::st_w-1:0]      s_n,
   output logic [pc_bus_pkg::addr_w-1:0]    ad_out,
   local_bus_if.master                      bus
);

   // T states
   localparam logic [2:0] t_idle = 3'd0;
   localparam logic [2:0] t1     = 3'd1;
   localparam logic [2:0] t2     = 3'd2;
   localparam logic [2:0] t3     = 3'd3;
   localparam logic [2:0] t4     = 3'd4;

   logic [2:0]                      t_state;
   logic [pc_bus_pkg::st_w-1:0]     kind_q;
   logic [pc_bus_pkg::addr_w-1:0]   addr_q;
   logic [pc_bus_pkg::data_w-1:0]   wdata_q;
   logic                            is_write;
   logic                            data_valid;

   assign is_write = (kind_q == pc_bus_pkg::st_mem_write) ||
                     (kind_q == pc_bus_pkg::st_io_write);

   // Transceiver is pointed at us only in a read data phase
   assign data_valid = bus.den && !bus.dtr;

   always_ff @(posedge clk) begin
      if (rst) begin
         t_state <= t_idle;
      end else begin
         case (t_state)
            t_idle:  if (req) t_state <= t1;
            t1:      if (bus.ale) t_state <= t2; // Stretch T1 until ALE
            t2:      t_state <= t3;
            t3:      t_state <= t4;
            t4:      t_state <= t_idle;
            default: t_state <= t_idle;
         endcase
      end
   end

   // Request payload
   always_ff @(posedge clk) begin
      if (t_state == t_idle && req) begin
         kind_q  <= req_kind;
         addr_q  <= req_addr;
         wdata_q <= req_wdata;
      end
   end

   // Read data sampled at the end of T3
   always_ff @(posedge clk) begin
      if (t_state == t3 && !is_write) begin
         rdata <= data_valid ? ad_in : '1;
      end
   end

   // Status is active in T1 and T2 only
   always_comb begin
      s_n = pc_bus_pkg::st_passive;
      if (t_state == t1 || t_state == t2) s_n = kind_q;
   end

   always_comb begin
      ad_out = '0;
      if (t_state == t1) begin
         ad_out = addr_q;
      end else if ((t_state == t2 || t_state == t3) && is_write) begin
         ad_out = {{(pc_bus_pkg::addr_w - pc_bus_pkg::data_w){1'b0}}, wdata_q};
      end
   end

   assign ready = (t_state == t_idle);
   assign done  = (t_state == t4);

endmodule

// ==== src/bus_demux.sv ====
`timescale 1ns/1ps

module bus_demux (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [pc_bus_pkg::addr_w-1:0] ad_out,
   input  logic [pc_bus_pkg::data_w-1:0] rd_data,
   output pc_bus_pkg::bus_addr_u         addr,
   output logic [pc_bus_pkg::data_w-1:0] wr_data,
   output logic [pc_bus_pkg::data_w-1:0] ad_in,
   local_bus_if.demux                    bus
);

   logic xcvr_tx; // Master to target
   logic xcvr_rx; // Target to master

   assign xcvr_tx = bus.den && bus.dtr;
   assign xcvr_rx = bus.den && !bus.dtr;

   // Address latch, transparent phase folded into the ALE edge
   always_ff @(posedge clk) begin
      if (rst) begin
         addr.mem <= '0;
      end else if (bus.ale) begin
         addr.mem <= ad_out;
      end
   end

   // Write side of the transceiver
   always_comb begin
      wr_data = '0;
      if (xcvr_tx) wr_data = ad_out[pc_bus_pkg::data_w-1:0];
   end

   // Read side, undriven bus floats high
   always_comb begin
      ad_in = '1;
      if (xcvr_rx) ad_in = rd_data;
   end

endmodule

// ==== src/local_bus_if.sv ====
`timescale 1ns/1ps

interface local_bus_if;

   // Command strobes, active low
   logic mrdc_n;
   logic amwc_n;
   logic iorc_n;
   logic aiowc_n;
   logic inta_n;

   // Bus control
   logic dtr; // High for transmit (write), low for receive
   logic den;
   logic ale;

   modport ctrl (
      output mrdc_n, amwc_n, iorc_n, aiowc_n, inta_n,
      output dtr, den, ale
   );

   modport master (input ale, den, dtr);

   modport demux (input ale, den, dtr);

   modport target (input mrdc_n, amwc_n, iorc_n, aiowc_n, inta_n);

endinterface

// ==== src/mem_io_target.sv ====
`timescale 1ns/1ps

module mem_io_target #(
   parameter int                          mem_depth  = 256,
   parameter int                          io_ports   = 4,
   parameter logic [pc_bus_pkg::data_w-1:0] int_vector = 8'h08
) (
   input  logic                          clk,
   input  logic                          rst,
   input  pc_bus_pkg::bus_addr_u         addr,
   input  logic [pc_bus_pkg::data_w-1:0] wr_data,
   output logic [pc_bus_pkg::data_w-1:0] rd_data,
   local_bus_if.target                   bus
);

   localparam int mem_aw = $clog2(mem_depth);
   localparam int port_w = $clog2(io_ports);

   logic [pc_bus_pkg::data_w-1:0] mem [mem_depth];
   logic [pc_bus_pkg::data_w-1:0] port_regs [io_ports];

   logic [mem_aw-1:0] mem_idx;
   logic [port_w-1:0] port_idx;
   logic              wr_strobe;
   logic              wr_seen;   // A write strobe was low last cycle
   logic              mem_we;
   logic              io_we;

   assign mem_idx  = addr.mem[mem_aw-1:0];      // Aliases modulo mem_depth
   assign port_idx = addr.io.port[port_w-1:0];  // Low port bits only

   assign wr_strobe = !bus.amwc_n || !bus.aiowc_n;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_seen <= 1'b0;
      end else begin
         wr_seen <= wr_strobe;
      end
   end

   // Second strobe cycle is the last one, data is settled by then
   assign mem_we = !bus.amwc_n && wr_seen;
   assign io_we  = !bus.aiowc_n && wr_seen;

   always_ff @(posedge clk) begin
      if (mem_we) mem[mem_idx] <= wr_data;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < io_ports; i++) begin
            port_regs[i] <= '0;
         end
      end else if (io_we) begin
         port_regs[port_idx] <= wr_data;
      end
   end

   // Read mux, selected by whichever read strobe is low
   always_comb begin
      rd_data = '1;
      if (!bus.mrdc_n) begin
         rd_data = mem[mem_idx];
      end else if (!bus.iorc_n) begin
         rd_data = port_regs[port_idx];
      end else if (!bus.inta_n) begin
         rd_data = int_vector; // Vector byte of the INTA cycle
      end
   end

endmodule

// ==== src/pc_bus_pkg.sv ====
package pc_bus_pkg;

   // Bus widths
   localparam int addr_w = 20;
   localparam int data_w = 8;
   localparam int st_w   = 3;

   // 8288 status codes on s_n[2:0]
   localparam logic [st_w-1:0] st_inta      = 3'b000;
   localparam logic [st_w-1:0] st_io_read   = 3'b001;
   localparam logic [st_w-1:0] st_io_write  = 3'b010;
   localparam logic [st_w-1:0] st_halt      = 3'b011; // Passive to the controller
   localparam logic [st_w-1:0] st_code      = 3'b100; // Opcode fetch, memory read
   localparam logic [st_w-1:0] st_mem_read  = 3'b101;
   localparam logic [st_w-1:0] st_mem_write = 3'b110;
   localparam logic [st_w-1:0] st_passive   = 3'b111;

   // I/O view of the latched address
   localparam int io_page_w = 4;
   localparam int io_port_w = 16;

   // Latched bus address
   // A memory cycle uses the whole word, an I/O cycle only the port field
   typedef union packed {
      logic [addr_w-1:0] mem;
      struct packed {
         logic [io_page_w-1:0] page; // Upper nibble, ignored by I/O decode
         logic [io_port_w-1:0] port;
      } io;
   } bus_addr_u;

endpackage

// ==== src/pc_bus_top.sv ====
`timescale 1ns/1ps

module pc_bus_top #(
   parameter int                            mem_depth  = 256,
   parameter int                            io_ports   = 4,
   parameter logic [pc_bus_pkg::data_w-1:0] int_vector = 8'h08
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          req,
   input  logic [pc_bus_pkg::st_w-1:0]   req_kind,  // Status code of the cycle
   input  logic [pc_bus_pkg::addr_w-1:0] req_addr,
   input  logic [pc_bus_pkg::data_w-1:0] req_wdata,
   input  logic                          aen_n,
   input  logic                          cen,
   output logic                          ready,
   output logic                          done,
   output logic [pc_bus_pkg::data_w-1:0] rdata
);

   logic [pc_bus_pkg::st_w-1:0]   s_n;
   logic [pc_bus_pkg::addr_w-1:0] ad_out;
   logic [pc_bus_pkg::data_w-1:0] ad_in;
   logic [pc_bus_pkg::data_w-1:0] wr_data;
   logic [pc_bus_pkg::data_w-1:0] rd_data;
   pc_bus_pkg::bus_addr_u         addr;

   local_bus_if bus_if ();

   bus_cycle_unit u_bcu (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .req_kind  (req_kind),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .ad_in     (ad_in),
      .ready     (ready),
      .done      (done),
      .rdata     (rdata),
      .s_n       (s_n),
      .ad_out    (ad_out),
      .bus       (bus_if.master)
   );

   bus_controller u_ctrl (
      .clk   (clk),
      .rst   (rst),
      .s_n   (s_n),
      .aen_n (aen_n),
      .cen   (cen),
      .bus   (bus_if.ctrl)
   );

   bus_demux u_demux (
      .clk     (clk),
      .rst     (rst),
      .ad_out  (ad_out),
      .rd_data (rd_data),
      .addr    (addr),
      .wr_data (wr_data),
      .ad_in   (ad_in),
      .bus     (bus_if.demux)
   );

   mem_io_target #(
      .mem_depth  (mem_depth),
      .io_ports   (io_ports),
      .int_vector (int_vector)
   ) u_target (
      .clk     (clk),
      .rst     (rst),
      .addr    (addr),
      .wr_data (wr_data),
      .rd_data (rd_data),
      .bus     (bus_if.target)
   );

endmodule
